// File: verilog.f
hdl/demap_pkg.sv
hdl/demap.sv
hdl/axis_fifo_asym.sv
hdl/pbch_demap_top.sv
verif/tb_pbch_demap.sv

// File: Makefile
# Verilator build and run of the PBCH demapper testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_pbch_demap
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

# result taken from the log, not from the exit code of the binary
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_pbch_demap.sv
`timescale 1ns/1ps

module tb_pbch_demap;

    import demap_pkg::*;

    localparam int SEED = 61504;

    // tready behavior per table entry
    localparam int RDY_HIGH = 0;
    localparam int RDY_RAND = 1;
    localparam int RDY_LOW  = 2;

    // narrow-side capacity, two LLRs per stored pair word
    localparam int LLR_CAP = 2 * (1 << FIFO_ADDR_W);

    // one stimulus row
    typedef struct packed {
        int                    test_id;
        logic [2*IQ_DW-1:0]    iq;
        logic [USER_DW-1:0]    tag;
        logic                  last;
        int                    idle;
        int                    rdy;
    } entry_t;

    // one expected output beat
    typedef struct packed {
        llr_t                  llr;
        logic [USER_DW-1:0]    user;
        logic                  last;
    } exp_t;

    logic                  clk_i;
    logic                  reset_ni;
    logic [2*IQ_DW-1:0]    s_axis_in_tdata;
    logic [USER_DW-1:0]    s_axis_in_tuser;
    logic                  s_axis_in_tlast;
    logic                  s_axis_in_tvalid;
    llr_t                  m_axis_out_tdata;
    logic [USER_DW-1:0]    m_axis_out_tuser;
    logic                  m_axis_out_tlast;
    logic                  m_axis_out_tvalid;
    logic                  m_axis_out_tready;
    logic                  overflow;

    entry_t table_q[$];
    exp_t   exp_q[$];
    exp_t   exp_head;
    logic   table_ready;
    logic   exp_overflow;
    int     rdy_mode;
    int     pushed;
    int     received;
    int     n_checks;
    int     err_total;
    int     test_err;
    int     tests_failed;

    pbch_demap_top UUT (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .s_axis_in_tdata   (s_axis_in_tdata),
        .s_axis_in_tuser   (s_axis_in_tuser),
        .s_axis_in_tlast   (s_axis_in_tlast),
        .s_axis_in_tvalid  (s_axis_in_tvalid),
        .m_axis_out_tdata  (m_axis_out_tdata),
        .m_axis_out_tuser  (m_axis_out_tuser),
        .m_axis_out_tlast  (m_axis_out_tlast),
        .m_axis_out_tvalid (m_axis_out_tvalid),
        .m_axis_out_tready (m_axis_out_tready),
        .overflow          (overflow)
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    task automatic note_error();
        err_total++;
        test_err++;
    endtask

    task automatic check_llr(input string name, input llr_t got, input llr_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            note_error();
        end
    endtask

    task automatic check_user(input string name, input logic [USER_DW-1:0] got,
                              input logic [USER_DW-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            note_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            note_error();
        end
    endtask

    // soft bit = upper byte of the component, sign kept
    function automatic llr_t upper_llr(input logic [IQ_DW-1:0] comp);
        logic signed [IQ_DW-1:0] s;
        s = comp;
        return llr_t'(s >>> (IQ_DW - LLR_DW));
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset state";
            2:       return "pbch llr values";
            3:       return "tag filtering";
            4:       return "tlast placement";
            5:       return "random tready";
            default: return "overflow under stall";
        endcase
    endfunction

    task automatic add_entry(input int t, input logic [2*IQ_DW-1:0] iq,
                             input logic [USER_DW-1:0] tag, input logic last,
                             input int idle, input int rdy);
        entry_t e;
        e.test_id = t;
        e.iq      = iq;
        e.tag     = tag;
        e.last    = last;
        e.idle    = idle;
        e.rdy     = rdy;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [USER_DW-1:0] tag;
        // plain PBCH, back to back and spaced
        add_entry(2, 32'h40FF_C001, PBCH_TAG, 1'b0, 0, RDY_HIGH);
        add_entry(2, 32'h8000_7FFF, PBCH_TAG, 1'b0, 0, RDY_HIGH);
        add_entry(2, 32'h0180_FE7F, PBCH_TAG, 1'b0, 2, RDY_HIGH);
        add_entry(2, 32'hA55A_5AA5, PBCH_TAG, 1'b0, 1, RDY_HIGH);
        // other channel types mixed in
        add_entry(3, 32'h1111_2222, 2'd0, 1'b0, 0, RDY_HIGH);
        add_entry(3, 32'h3344_5566, PBCH_TAG, 1'b0, 0, RDY_HIGH);
        add_entry(3, 32'h7788_99AA, 2'd2, 1'b0, 0, RDY_HIGH);
        add_entry(3, 32'hBBCC_DDEE, 2'd3, 1'b0, 1, RDY_HIGH);
        add_entry(3, 32'hF00F_0FF0, PBCH_TAG, 1'b0, 0, RDY_HIGH);
        add_entry(3, 32'hDEAD_BEEF, 2'd3, 1'b0, 0, RDY_HIGH);
        add_entry(3, 32'hCAFE_F00D, 2'd0, 1'b0, 0, RDY_HIGH);
        add_entry(3, 32'h1234_5678, PBCH_TAG, 1'b0, 2, RDY_HIGH);
        // last on kept and on dropped symbols
        add_entry(4, 32'h0A0B_0C0D, PBCH_TAG, 1'b0, 0, RDY_HIGH);
        add_entry(4, 32'h1A1B_1C1D, PBCH_TAG, 1'b1, 0, RDY_HIGH);
        add_entry(4, 32'h2A2B_2C2D, 2'd2, 1'b1, 0, RDY_HIGH);
        add_entry(4, 32'h3A3B_3C3D, PBCH_TAG, 1'b0, 1, RDY_HIGH);
        add_entry(4, 32'h4A4B_4C4D, 2'd0, 1'b1, 0, RDY_HIGH);
        add_entry(4, 32'h5A5B_5C5D, PBCH_TAG, 1'b1, 2, RDY_HIGH);
        // random traffic, input rate kept below the random drain rate
        for (int k = 0; k < 24; k++) begin
            tag = ($urandom % 2) ? PBCH_TAG : 2'($urandom % 4);
            add_entry(5, $urandom, tag, 1'($urandom & 1), 2 + int'($urandom % 4),
                      RDY_RAND);
        end
        // more pairs than the FIFO holds, nothing drained meanwhile
        for (int k = 0; k < 20; k++) begin
            add_entry(6, {8'(k), 8'h5C, 8'(255 - k), 8'h33}, PBCH_TAG,
                      1'(k % 5 == 4), 1, RDY_LOW);
        end
    endtask

    // one clock, input idle unless the caller drives it again
    task automatic cycle();
        @(posedge clk_i);
        s_axis_in_tvalid <= 1'b0;
        case (rdy_mode)
            RDY_HIGH: m_axis_out_tready <= 1'b1;
            RDY_RAND: m_axis_out_tready <= 1'($urandom & 1);
            default:  m_axis_out_tready <= 1'b0;
        endcase
    endtask

    // reference model, I beat then Q beat, or a predicted drop
    task automatic expect_symbol(input logic [2*IQ_DW-1:0] iq, input logic last);
        exp_t ei;
        exp_t eq;
        if (pushed - received > LLR_CAP - 2) begin
            exp_overflow = 1'b1;
        end else begin
            ei.llr  = upper_llr(iq[IQ_DW-1:0]);
            ei.user = PBCH_TAG;
            ei.last = 1'b0;
            eq.llr  = upper_llr(iq[2*IQ_DW-1:IQ_DW]);
            eq.user = PBCH_TAG;
            eq.last = last;
            exp_q.push_back(ei);
            exp_q.push_back(eq);
            pushed += 2;
        end
    endtask

    task automatic apply_entry(input entry_t e);
        rdy_mode = e.rdy;
        cycle();
        s_axis_in_tdata  <= e.iq;
        s_axis_in_tuser  <= e.tag;
        s_axis_in_tlast  <= e.last;
        s_axis_in_tvalid <= 1'b1;
        if (e.tag == PBCH_TAG) begin
            expect_symbol(e.iq, e.last);
        end
        for (int k = 0; k < e.idle; k++) begin
            cycle();
        end
    endtask

    task automatic report_test(input int t);
        if (test_err != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", t, test_name(t),
                 (test_err == 0) ? "ok" : "failed", test_err);
    endtask

    // flush the pipe, check the flag, drain, then look for stray beats
    task automatic close_test(input int t);
        repeat (3) cycle();
        @(negedge clk_i);
        check_flag("overflow", overflow, exp_overflow);
        rdy_mode = RDY_HIGH;
        while (exp_q.size() != 0) begin
            cycle();
        end
        repeat (8) cycle();
        @(negedge clk_i);
        check_flag("overflow", overflow, exp_overflow);
        report_test(t);
    endtask

    // output monitor, mid-cycle so handshake and data are settled
    always @(negedge clk_i) begin
        if (reset_ni && m_axis_out_tvalid && m_axis_out_tready) begin
            received++;
            if (exp_q.size() == 0) begin
                $display("output beat 0x%h arrived when no LLR was expected",
                         m_axis_out_tdata);
                note_error();
            end else begin
                exp_head = exp_q.pop_front();
                check_llr("m_axis_out_tdata", m_axis_out_tdata, exp_head.llr);
                check_user("m_axis_out_tuser", m_axis_out_tuser, exp_head.user);
                check_flag("m_axis_out_tlast", m_axis_out_tlast, exp_head.last);
            end
        end
    end

    // watchdog, scaled to the table
    initial begin
        wait (table_ready);
        repeat (table_q.size() * 40) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", table_q.size() * 40);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int last_idx;
        clk_i             = 1'b0;
        reset_ni          = 1'b0;
        s_axis_in_tdata   = '0;
        s_axis_in_tuser   = '0;
        s_axis_in_tlast   = 1'b0;
        s_axis_in_tvalid  = 1'b0;
        m_axis_out_tready = 1'b1;
        rdy_mode          = RDY_HIGH;
        exp_overflow      = 1'b0;
        table_ready       = 1'b0;
        pushed            = 0;
        received          = 0;
        n_checks          = 0;
        err_total         = 0;
        test_err          = 0;
        tests_failed      = 0;
        void'($urandom(SEED));
        build_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        check_flag("m_axis_out_tvalid", m_axis_out_tvalid, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        report_test(1);

        last_idx = table_q.size() - 1;
        for (int n = 0; n <= last_idx; n++) begin
            if (n == 0 || table_q[n].test_id != table_q[n-1].test_id) begin
                test_err = 0;
            end
            apply_entry(table_q[n]);
            if (n == last_idx || table_q[n+1].test_id != table_q[n].test_id) begin
                close_test(table_q[n].test_id);
            end
        end

        $display("tests 6, failed %0d, checks %0d, errors %0d",
                 tests_failed, n_checks, err_total);
        if (err_total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/pbch_demap_top.sv
`timescale 1ns/1ps

module pbch_demap_top (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic [2*demap_pkg::IQ_DW-1:0]   s_axis_in_tdata,
    input  logic [demap_pkg::USER_DW-1:0]   s_axis_in_tuser,
    input  logic                            s_axis_in_tlast,
    input  logic                            s_axis_in_tvalid,
    output demap_pkg::llr_t                 m_axis_out_tdata,
    output logic [demap_pkg::USER_DW-1:0]   m_axis_out_tuser,
    output logic                            m_axis_out_tlast,
    output logic                            m_axis_out_tvalid,
    input  logic                            m_axis_out_tready,
    output logic                            overflow
);

    import demap_pkg::*;

    // pair stream from demapper to FIFO, one LLR pair per kept symbol
    llr_pair_u          pair_data;
    logic [USER_DW-1:0] pair_user;
    logic               pair_last;
    logic               pair_valid;

    // symbol filter and QPSK demapper
    // no ready on the input, every valid edge is taken
    demap u_demap (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .s_axis_in_tdata  (s_axis_in_tdata),
        .s_axis_in_tuser  (s_axis_in_tuser),
        .s_axis_in_tlast  (s_axis_in_tlast),
        .s_axis_in_tvalid (s_axis_in_tvalid),
        .pair_data        (pair_data),
        .pair_user        (pair_user),
        .pair_last        (pair_last),
        .pair_valid       (pair_valid)
    );

    // pair to single LLR width conversion
    // absorbs output back-pressure up to 16 pairs
    axis_fifo_asym u_fifo (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .pair_data         (pair_data),
        .pair_user         (pair_user),
        .pair_last         (pair_last),
        .pair_valid        (pair_valid),
        .m_axis_out_tready (m_axis_out_tready),
        .m_axis_out_tdata  (m_axis_out_tdata),
        .m_axis_out_tuser  (m_axis_out_tuser),
        .m_axis_out_tlast  (m_axis_out_tlast),
        .m_axis_out_tvalid (m_axis_out_tvalid),
        .overflow          (overflow)
    );

endmodule

// File: hdl/axis_fifo_asym.sv
`timescale 1ns/1ps

module axis_fifo_asym (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  demap_pkg::llr_pair_u            pair_data,
    input  logic [demap_pkg::USER_DW-1:0]   pair_user,
    input  logic                            pair_last,
    input  logic                            pair_valid,
    input  logic                            m_axis_out_tready,
    output demap_pkg::llr_t                 m_axis_out_tdata,
    output logic [demap_pkg::USER_DW-1:0]   m_axis_out_tuser,
    output logic                            m_axis_out_tlast,
    output logic                            m_axis_out_tvalid,
    output logic                            overflow
);

    import demap_pkg::*;

    // one pair word per entry plus its sideband
    logic [PAIR_DW-1:0] pair_mem [FIFO_DEPTH];
    logic [USER_DW-1:0] user_mem [FIFO_DEPTH];
    logic               last_mem [FIFO_DEPTH];

    // pointers carry one wrap bit above the address
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic [FIFO_ADDR_W:0] fill;

    logic [FIFO_ADDR_W-1:0] wr_addr;
    logic [FIFO_ADDR_W-1:0] rd_addr;

    logic empty;
    logic full;
    logic wr_en;

    // handshake of the narrow side
    logic beat_done;

    // low picks the i lane of the head word and high the q lane
    logic lane_sel;

    // head word decoded into its lanes
    llr_pair_u head;

    assign wr_addr = wr_ptr[FIFO_ADDR_W-1:0];
    assign rd_addr = rd_ptr[FIFO_ADDR_W-1:0];

    // occupancy in pair words from 0 to 16
    assign fill  = wr_ptr - rd_ptr;
    assign empty = (fill == '0);

    // only a full store sets the wrap-difference bit
    assign full  = fill[FIFO_ADDR_W];

    // writes while full are lost
    assign wr_en = pair_valid && !full;

    assign beat_done = m_axis_out_tvalid && m_axis_out_tready;

    // wide word stored as is on the write side
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            pair_mem[wr_addr] <= pair_data.raw;
            user_mem[wr_addr] <= pair_user;
            last_mem[wr_addr] <= pair_last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read pointer and lane select
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_ptr   <= '0;
            lane_sel <= 1'b0;
        end else if (beat_done) begin
            lane_sel <= !lane_sel;
            // head word retired only with its q beat
            if (lane_sel) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // sticky drop flag
    // stays set until the next reset
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            overflow <= 1'b0;
        end else if (pair_valid && full) begin
            overflow <= 1'b1;
        end
    end

    // head word always visible as the first word falls through
    assign head.raw = pair_mem[rd_addr];

    assign m_axis_out_tvalid = !empty;

    // narrow side gives i then q of the head word
    assign m_axis_out_tdata = lane_sel ? head.lane.q : head.lane.i;
    assign m_axis_out_tuser = user_mem[rd_addr];

    // frame end belongs to the last soft bit of the symbol
    assign m_axis_out_tlast = lane_sel && last_mem[rd_addr];

    // a stalled beat must not change under the consumer
    property p_hold_on_stall;
        @(posedge clk_i) disable iff (!reset_ni)
            (m_axis_out_tvalid && !m_axis_out_tready) |=>
                (m_axis_out_tvalid
                 && $stable(m_axis_out_tdata)
                 && $stable(m_axis_out_tuser)
                 && $stable(m_axis_out_tlast));
    endproperty

    a_hold_on_stall: assert property (p_hold_on_stall)
        else $error("fifo: output changed while stalled");

    // neither pointer runs past the other
    property p_ptr_order;
        @(posedge clk_i) disable iff (!reset_ni)
            fill <= FIFO_DEPTH;
    endproperty

    a_ptr_order: assert property (p_ptr_order)
        else $error("fifo: pointer overrun, fill %0d", fill);

    // tlast only ever on the q beat
    property p_last_on_q;
        @(posedge clk_i) disable iff (!reset_ni)
            (m_axis_out_tvalid && !lane_sel) |-> !m_axis_out_tlast;
    endproperty

    a_last_on_q: assert property (p_last_on_q)
        else $error("fifo: tlast on an i beat");

endmodule

// File: hdl/demap.sv
`timescale 1ns/1ps

module demap (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic [2*demap_pkg::IQ_DW-1:0]   s_axis_in_tdata,
    input  logic [demap_pkg::USER_DW-1:0]   s_axis_in_tuser,
    input  logic                            s_axis_in_tlast,
    input  logic                            s_axis_in_tvalid,
    output demap_pkg::llr_pair_u            pair_data,
    output logic [demap_pkg::USER_DW-1:0]   pair_user,
    output logic                            pair_last,
    output logic                            pair_valid
);

    import demap_pkg::*;

    // symbol is kept only when valid and tagged PBCH
    logic in_pbch;

    // hard-truncated soft bits of the current input symbol
    llr_t llr_i;
    llr_t llr_q;

    assign in_pbch = s_axis_in_tvalid && (s_axis_in_tuser == PBCH_TAG);

    // QPSK maps each component to one bit
    // upper LLR_DW bits of the component with the low bits dropped
    assign llr_i = s_axis_in_tdata[IQ_DW-1 -: LLR_DW];
    assign llr_q = s_axis_in_tdata[2*IQ_DW-1 -: LLR_DW];

    // one cycle of valid per kept symbol
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= in_pbch;
        end
    end

    // pair payload loaded only for kept symbols
    // holds between kept symbols
    always_ff @(posedge clk_i) begin
        if (in_pbch) begin
            pair_data.lane.i <= llr_i;
            pair_data.lane.q <= llr_q;
            pair_user        <= s_axis_in_tuser;
            pair_last        <= s_axis_in_tlast;
        end
    end

    // every pair strobe traces back to a PBCH symbol one edge earlier
    property p_pair_from_pbch;
        @(posedge clk_i) disable iff (!reset_ni)
            pair_valid |-> $past(in_pbch);
    endproperty

    a_pair_from_pbch: assert property (p_pair_from_pbch)
        else $error("demap: pair_valid without a preceding PBCH input");

endmodule

// File: hdl/demap_pkg.sv
package demap_pkg;

    // one IQ component, input word carries I low and Q high
    localparam int IQ_DW = 16;

    // one soft bit
    localparam int LLR_DW = 8;

    // symbol tag width, channel type of each symbol
    localparam int USER_DW = 2;

    // tag value of PBCH symbols
    localparam logic [USER_DW-1:0] PBCH_TAG = 2'd1;

    // wide side of the output FIFO holds one LLR pair per word
    localparam int PAIR_DW = 2 * LLR_DW;

    // 16 pair words, i.e. 32 LLRs on the narrow side
    localparam int FIFO_ADDR_W = 4;
    localparam logic [FIFO_ADDR_W:0] FIFO_DEPTH = {1'b1, {FIFO_ADDR_W{1'b0}}};

    // signed soft bit, sign follows the component sign
    typedef logic signed [LLR_DW-1:0] llr_t;

    // lane layout of one pair word, q in the upper byte
    typedef struct packed {
        llr_t q;
        llr_t i;
    } llr_lanes_t;

    // same 16 bits seen as storage word or as two lanes
    typedef union packed {
        logic [PAIR_DW-1:0] raw;
        llr_lanes_t         lane;
    } llr_pair_u;

endpackage
